// File: list.f
+incdir+verilog
verilog/l1d_pkg.sv
verilog/l1d_line_store.sv
verilog/l1d_mshr_file.sv
verilog/l1d_controller.sv
verilog/l1_data_cache.sv
testbench/l1_data_cache_tb.sv

// File: testbench/l1_data_cache_tb.sv
// L1 data cache testbench

`include "l1d_defines.svh"

`default_nettype none

module l1_data_cache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import l1d_pkg::*;

  localparam int CLK_PERIOD         = 20;
  localparam int RESET_CYCLES       = 5;
  localparam int WORD_BITS          = `L1D_WORD_BITS;
  localparam int OFFSET_BITS        = `L1D_OFFSET_BITS;
  localparam int WORD_BYTES         = `L1D_WORD_BITS / 8;
  localparam int WORDS_PER_LINE     = `L1D_LINE_BYTES / WORD_BYTES;
  localparam int DEFAULT_FILL_DELAY = 4;

  // cycle budgets per test, their sum sizes the watchdog
  localparam int BUDGET_COLD  = 60;
  localparam int BUDGET_HIT   = 40;
  localparam int BUDGET_WRITE = 60;
  localparam int BUDGET_MERGE = 100;
  localparam int BUDGET_EVICT = 150;
  localparam int BUDGET_NB    = 150;
  localparam int BUDGET_TOTAL = RESET_CYCLES + BUDGET_COLD + BUDGET_HIT + BUDGET_WRITE +
                                BUDGET_MERGE + BUDGET_EVICT + BUDGET_NB + 20;

  logic      clk_in;
  logic      rst_N_in;
  logic      lsu_req_valid;
  lsu_req_t  lsu_req;
  logic      lsu_req_ready;
  logic      lsu_resp_valid;
  lsu_resp_t lsu_resp;
  logic      lsu_resp_ready;
  logic      lc_req_valid;
  lc_req_t   lc_req;
  logic      lc_req_ready;
  logic      lc_fill_valid;
  lc_fill_t  lc_fill;
  logic      lc_fill_ready;

  int   errors;
  int   checks;
  int   cycle;
  logic fill_done;

  lc_req_t                   lc_log [$];
  lsu_resp_t                 resp_log [$];
  block_addr_t               pend_block [$];
  int                        pend_due [$];
  int                        fill_delays [$];
  block_addr_t               written_blocks [$];
  logic [`L1D_LINE_BITS-1:0] written_lines [$];

  l1_data_cache l1_data_cache_inst (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req        (lsu_req),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp       (lsu_resp),
    .lsu_resp_ready (lsu_resp_ready),
    .lc_req_valid   (lc_req_valid),
    .lc_req         (lc_req),
    .lc_req_ready   (lc_req_ready),
    .lc_fill_valid  (lc_fill_valid),
    .lc_fill        (lc_fill),
    .lc_fill_ready  (lc_fill_ready)
  );

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  function automatic block_addr_t block_of(input paddr_u a);
    return {a.f.tag, a.f.index};
  endfunction

  // untouched memory holds each word's byte address shifted left 8, plus 0x5a
  function automatic logic [`L1D_LINE_BITS-1:0] model_line(input block_addr_t blk);
    logic [`L1D_LINE_BITS-1:0] line;
    logic [`L1D_WORD_BITS-1:0] word_addr;
    for (int i = 0; i < written_blocks.size(); i++) begin
      if (written_blocks[i] == blk) begin
        return written_lines[i];
      end
    end
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      word_addr = (WORD_BITS'(blk) << OFFSET_BITS) + WORD_BITS'(w * WORD_BYTES);
      line[w*WORD_BITS +: WORD_BITS] = (word_addr << 8) + 64'h5a;
    end
    return line;
  endfunction

  function automatic logic [`L1D_WORD_BITS-1:0] model_word(input paddr_u a);
    logic [`L1D_LINE_BITS-1:0] line;
    int                        w;
    line = model_line(block_of(a));
    w    = int'(a.f.offset) / WORD_BYTES;
    return line[w*WORD_BITS +: WORD_BITS];
  endfunction

  function automatic void store_line(input block_addr_t blk,
                                     input logic [`L1D_LINE_BITS-1:0] line);
    for (int i = 0; i < written_blocks.size(); i++) begin
      if (written_blocks[i] == blk) begin
        written_lines[i] = line;
        return;
      end
    end
    written_blocks.push_back(blk);
    written_lines.push_back(line);
  endfunction

  // every handshake completes on a rising edge, so the lower memory records it there
  always @(posedge clk_in) begin : handshake_monitor
    int delay;
    cycle++;
    if (rst_N_in) begin
      if (lc_req_valid && lc_req_ready) begin
        lc_log.push_back(lc_req);
        if (lc_req.we) begin
          store_line(lc_req.block, lc_req.line);
        end else begin
          delay = DEFAULT_FILL_DELAY;
          if (fill_delays.size() > 0) begin
            delay = fill_delays.pop_front();
          end
          pend_block.push_back(lc_req.block);
          pend_due.push_back(cycle + delay);
        end
      end
      if (lsu_resp_valid && lsu_resp_ready) begin
        resp_log.push_back(lsu_resp);
      end
      if (lc_fill_valid && lc_fill_ready) begin
        fill_done = 1'b1;
      end
    end
  end

  // the earliest due line read is answered first
  always @(negedge clk_in) begin : fill_driver
    int pick;
    if (fill_done) begin
      lc_fill_valid = 1'b0;
      fill_done     = 1'b0;
    end
    if (!lc_fill_valid) begin
      pick = -1;
      for (int i = 0; i < pend_due.size(); i++) begin
        if (pend_due[i] <= cycle && (pick < 0 || pend_due[i] < pend_due[pick])) begin
          pick = i;
        end
      end
      if (pick >= 0) begin
        lc_fill_valid = 1'b1;
        lc_fill.block = pend_block[pick];
        lc_fill.line  = model_line(pend_block[pick]);
        pend_block.delete(pick);
        pend_due.delete(pick);
      end
    end
  end

  function automatic paddr_u make_addr(input logic [`L1D_TAG_BITS-1:0] tag,
                                       input logic [`L1D_INDEX_BITS-1:0] index,
                                       input int word);
    paddr_u a;
    a.f.tag    = tag;
    a.f.index  = index;
    a.f.offset = OFFSET_BITS'(word * WORD_BYTES);
    return a;
  endfunction

  function automatic lsu_req_t make_req(input paddr_u a, input logic we,
                                        input logic [`L1D_WORD_BITS-1:0] value,
                                        input logic [`L1D_REQ_TAG_BITS-1:0] tag);
    lsu_req_t r;
    r.addr  = a;
    r.we    = we;
    r.value = value;
    r.tag   = tag;
    return r;
  endfunction

  function automatic string resp_text(input lsu_resp_t r);
    return $sformatf("addr %h write %b value %h tag %h", r.addr, r.write, r.value, r.tag);
  endfunction

  function automatic string lc_text(input lc_req_t r, input logic with_line);
    if (with_line) begin
      return $sformatf("block %h we %b line %h", r.block, r.we, r.line);
    end else begin
      return $sformatf("block %h we %b", r.block, r.we);
    end
  endfunction

  task automatic check_resp(input string name, input lsu_resp_t exp, input lsu_resp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %s, got %s", name, resp_text(exp), resp_text(act));
    end
  endtask

  task automatic check_lc_req(input string name, input lc_req_t exp, input lc_req_t act,
                              input logic with_line);
    checks++;
    if (act.block !== exp.block || act.we !== exp.we ||
        (with_line && act.line !== exp.line)) begin
      errors++;
      $display("error %s: expected %s, got %s", name,
               lc_text(exp, with_line), lc_text(act, with_line));
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("error %s: expected %0d %s, got %0d", name, exp, what, act);
    end
  endtask

  // line reads carry no data, so only evictions compare the line
  task automatic check_lc_at(input string name, input int idx, input block_addr_t blk,
                             input logic we, input logic [`L1D_LINE_BITS-1:0] line);
    lc_req_t exp;
    exp.block = blk;
    exp.we    = we;
    exp.line  = line;
    if (idx >= lc_log.size()) begin
      errors++;
      $display("%s: the lower cache never saw request number %0d", name, idx);
    end else begin
      check_lc_req(name, exp, lc_log[idx], we);
    end
  endtask

  task automatic expect_resp(input string name, input paddr_u a, input logic we,
                             input logic [`L1D_WORD_BITS-1:0] value,
                             input logic [`L1D_REQ_TAG_BITS-1:0] tag);
    lsu_resp_t exp;
    lsu_resp_t act;
    exp.addr  = a.raw;
    exp.write = we;
    exp.value = value;
    exp.tag   = tag;
    if (resp_log.size() == 0) begin
      errors++;
      $display("%s: the cache sent no response for request tag %h", name, tag);
    end else begin
      act = resp_log.pop_front();
      check_resp(name, exp, act);
    end
  endtask

  task automatic send_req(input lsu_req_t r);
    @(negedge clk_in);
    lsu_req_valid = 1'b1;
    lsu_req       = r;
    do begin
      @(posedge clk_in);
    end while (!lsu_req_ready);
    @(negedge clk_in);
    lsu_req_valid = 1'b0;
  endtask

  task automatic wait_resps(input string name, input int count, input int limit);
    int waited;
    waited = 0;
    while (resp_log.size() < count && waited < limit) begin
      @(negedge clk_in);
      waited++;
    end
    if (resp_log.size() < count) begin
      errors++;
      $display("%s: only %0d of %0d responses arrived within %0d cycles",
               name, resp_log.size(), count, limit);
    end
  endtask

  task automatic test_cold_read_miss();
    paddr_u a;
    int     base;
    a    = make_addr(12'h012, 4'h1, 2);
    base = lc_log.size();
    send_req(make_req(a, 1'b0, '0, 10'h011));
    wait_resps("cold_read_miss", 1, BUDGET_COLD);
    check_count("cold_read_miss", "lc requests", 1, lc_log.size() - base);
    check_lc_at("cold_read_miss", base, block_of(a), 1'b0, '0);
    expect_resp("cold_read_miss", a, 1'b0, model_word(a), 10'h011);
  endtask

  task automatic test_read_hit();
    paddr_u a;
    int     base;
    a    = make_addr(12'h012, 4'h1, 2);
    base = lc_log.size();
    send_req(make_req(a, 1'b0, '0, 10'h022));
    wait_resps("read_hit", 1, BUDGET_HIT);
    check_count("read_hit", "lc requests", 0, lc_log.size() - base);
    expect_resp("read_hit", a, 1'b0, model_word(a), 10'h022);
  endtask

  task automatic test_write_then_read();
    paddr_u                    a;
    logic [`L1D_WORD_BITS-1:0] value;
    int                        base;
    a     = make_addr(12'h012, 4'h1, 5);
    value = {$urandom(), $urandom()};
    base  = lc_log.size();
    send_req(make_req(a, 1'b1, value, 10'h033));
    wait_resps("write_then_read", 1, BUDGET_WRITE / 2);
    expect_resp("write_then_read", a, 1'b1, value, 10'h033);
    send_req(make_req(a, 1'b0, '0, 10'h034));
    wait_resps("write_then_read", 1, BUDGET_WRITE / 2);
    expect_resp("write_then_read", a, 1'b0, value, 10'h034);
    check_count("write_then_read", "lc requests", 0, lc_log.size() - base);
  endtask

  // the slow fill leaves time for the second request to join the MSHR
  task automatic test_secondary_merge();
    paddr_u                    a;
    logic [`L1D_WORD_BITS-1:0] value;
    int                        base;
    a     = make_addr(12'h045, 4'h3, 1);
    value = {$urandom(), $urandom()};
    base  = lc_log.size();
    fill_delays.push_back(30);
    send_req(make_req(a, 1'b1, value, 10'h041));
    send_req(make_req(a, 1'b0, '0, 10'h042));
    wait_resps("secondary_merge", 2, BUDGET_MERGE);
    check_count("secondary_merge", "lc requests", 1, lc_log.size() - base);
    check_lc_at("secondary_merge", base, block_of(a), 1'b0, '0);
    expect_resp("secondary_merge", a, 1'b1, value, 10'h041);
    expect_resp("secondary_merge", a, 1'b0, value, 10'h042);
  endtask

  task automatic test_dirty_eviction();
    paddr_u                    a;
    paddr_u                    b;
    logic [`L1D_WORD_BITS-1:0] value;
    logic [`L1D_LINE_BITS-1:0] victim_line;
    int                        base;
    a     = make_addr(12'h050, 4'h5, 4);
    b     = make_addr(12'h0a0, 4'h5, 4);
    value = {$urandom(), $urandom()};
    send_req(make_req(a, 1'b0, '0, 10'h051));
    wait_resps("dirty_eviction", 1, BUDGET_EVICT / 4);
    expect_resp("dirty_eviction", a, 1'b0, model_word(a), 10'h051);
    send_req(make_req(a, 1'b1, value, 10'h052));
    wait_resps("dirty_eviction", 1, BUDGET_EVICT / 4);
    expect_resp("dirty_eviction", a, 1'b1, value, 10'h052);
    victim_line = model_line(block_of(a));
    victim_line[4*WORD_BITS +: WORD_BITS] = value;
    base = lc_log.size();
    send_req(make_req(b, 1'b0, '0, 10'h053));
    wait_resps("dirty_eviction", 1, BUDGET_EVICT / 4);
    check_count("dirty_eviction", "lc requests", 2, lc_log.size() - base);
    check_lc_at("dirty_eviction", base, block_of(b), 1'b0, '0);
    check_lc_at("dirty_eviction", base + 1, block_of(a), 1'b1, victim_line);
    expect_resp("dirty_eviction", b, 1'b0, model_word(b), 10'h053);
    // the written word now comes back from the lower memory
    send_req(make_req(a, 1'b0, '0, 10'h054));
    wait_resps("dirty_eviction", 1, BUDGET_EVICT / 4);
    expect_resp("dirty_eviction", a, 1'b0, value, 10'h054);
  endtask

  task automatic test_nonblocking_misses();
    paddr_u c;
    paddr_u d;
    int     base;
    c    = make_addr(12'h061, 4'h7, 3);
    d    = make_addr(12'h062, 4'h8, 6);
    base = lc_log.size();
    fill_delays.push_back(40);
    fill_delays.push_back(10);
    send_req(make_req(c, 1'b0, '0, 10'h061));
    send_req(make_req(d, 1'b0, '0, 10'h062));
    wait_resps("nonblocking_misses", 2, BUDGET_NB);
    check_count("nonblocking_misses", "lc requests", 2, lc_log.size() - base);
    check_lc_at("nonblocking_misses", base, block_of(c), 1'b0, '0);
    check_lc_at("nonblocking_misses", base + 1, block_of(d), 1'b0, '0);
    expect_resp("nonblocking_misses", d, 1'b0, model_word(d), 10'h062);
    expect_resp("nonblocking_misses", c, 1'b0, model_word(c), 10'h061);
  endtask

  initial begin
    clk_in         = 1'b0;
    rst_N_in       = 1'b0;
    lsu_req_valid  = 1'b0;
    lsu_req        = '0;
    lsu_resp_ready = 1'b1;
    lc_req_ready   = 1'b1;
    lc_fill_valid  = 1'b0;
    lc_fill        = '0;
    errors         = 0;
    checks         = 0;
    cycle          = 0;
    fill_done      = 1'b0;
    void'($urandom(32'h06e7_03be));
    repeat (RESET_CYCLES) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b1;
    test_cold_read_miss();
    test_read_hit();
    test_write_then_read();
    test_secondary_merge();
    test_dirty_eviction();
    test_nonblocking_misses();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(BUDGET_TOTAL * CLK_PERIOD);
    $display("timeout after %0d cycles with %0d errors so far", BUDGET_TOTAL, errors);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/l1_data_cache.sv
// L1 data cache top level

`include "l1d_defines.svh"

`default_nettype none

module l1_data_cache (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic               lsu_req_valid,
  input  l1d_pkg::lsu_req_t  lsu_req,
  output logic               lsu_req_ready,
  output logic               lsu_resp_valid,
  output l1d_pkg::lsu_resp_t lsu_resp,
  input  logic               lsu_resp_ready,
  output logic               lc_req_valid,
  output l1d_pkg::lc_req_t   lc_req,
  input  logic               lc_req_ready,
  input  logic               lc_fill_valid,
  input  l1d_pkg::lc_fill_t  lc_fill,
  output logic               lc_fill_ready
);

  import l1d_pkg::*;

  // line store side
  paddr_u                    lookup_addr;
  logic                      word_we;
  logic [`L1D_WORD_BITS-1:0] word_value;
  logic                      fill_en;
  lc_fill_t                  fill;
  logic                      hit;
  logic [`L1D_WORD_BITS-1:0] read_word;
  logic                      victim_dirty;
  lc_req_t                   victim;

  // MSHR side
  block_addr_t               lookup_block;
  logic                      alloc_en;
  logic                      enq_en;
  lsu_req_t                  req;
  logic                      deq_en;
  mshr_id_t                  deq_id;
  logic                      match;
  mshr_id_t                  match_id;
  logic                      any_free;
  logic                      any_full;
  lsu_req_t                  head;
  logic                      head_valid;

  l1d_controller controller_inst (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req        (lsu_req),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp       (lsu_resp),
    .lsu_resp_ready (lsu_resp_ready),
    .lc_req_valid   (lc_req_valid),
    .lc_req         (lc_req),
    .lc_req_ready   (lc_req_ready),
    .lc_fill_valid  (lc_fill_valid),
    .lc_fill        (lc_fill),
    .lc_fill_ready  (lc_fill_ready),
    .lookup_addr    (lookup_addr),
    .word_we        (word_we),
    .word_value     (word_value),
    .fill_en        (fill_en),
    .fill           (fill),
    .hit            (hit),
    .read_word      (read_word),
    .victim_dirty   (victim_dirty),
    .victim         (victim),
    .lookup_block   (lookup_block),
    .alloc_en       (alloc_en),
    .enq_en         (enq_en),
    .req            (req),
    .deq_en         (deq_en),
    .deq_id         (deq_id),
    .match          (match),
    .match_id       (match_id),
    .any_free       (any_free),
    .any_full       (any_full),
    .head           (head),
    .head_valid     (head_valid)
  );

  l1d_line_store line_store_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .lookup_addr  (lookup_addr),
    .word_we      (word_we),
    .word_value   (word_value),
    .fill_en      (fill_en),
    .fill         (fill),
    .hit          (hit),
    .read_word    (read_word),
    .victim_dirty (victim_dirty),
    .victim       (victim)
  );

  l1d_mshr_file mshr_file_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .lookup_block (lookup_block),
    .alloc_en     (alloc_en),
    .enq_en       (enq_en),
    .req          (req),
    .deq_en       (deq_en),
    .deq_id       (deq_id),
    .match        (match),
    .match_id     (match_id),
    .any_free     (any_free),
    .any_full     (any_full),
    .head         (head),
    .head_valid   (head_valid)
  );

endmodule

`default_nettype wire

// File: verilog/l1d_controller.sv
// L1 data cache controller

`include "l1d_defines.svh"

`default_nettype none

module l1d_controller (
  input  logic                       clk_in,
  input  logic                       rst_N_in,
  input  logic                       lsu_req_valid,
  input  l1d_pkg::lsu_req_t          lsu_req,
  output logic                       lsu_req_ready,
  output logic                       lsu_resp_valid,
  output l1d_pkg::lsu_resp_t         lsu_resp,
  input  logic                       lsu_resp_ready,
  output logic                       lc_req_valid,
  output l1d_pkg::lc_req_t           lc_req,
  input  logic                       lc_req_ready,
  input  logic                       lc_fill_valid,
  input  l1d_pkg::lc_fill_t          lc_fill,
  output logic                       lc_fill_ready,
  output l1d_pkg::paddr_u            lookup_addr,
  output logic                       word_we,
  output logic [`L1D_WORD_BITS-1:0]  word_value,
  output logic                       fill_en,
  output l1d_pkg::lc_fill_t          fill,
  input  logic                       hit,
  input  logic [`L1D_WORD_BITS-1:0]  read_word,
  input  logic                       victim_dirty,
  input  l1d_pkg::lc_req_t           victim,
  output l1d_pkg::block_addr_t       lookup_block,
  output logic                       alloc_en,
  output logic                       enq_en,
  output l1d_pkg::lsu_req_t          req,
  output logic                       deq_en,
  output l1d_pkg::mshr_id_t          deq_id,
  input  logic                       match,
  input  l1d_pkg::mshr_id_t          match_id,
  input  logic                       any_free,
  input  logic                       any_full,
  input  l1d_pkg::lsu_req_t          head,
  input  logic                       head_valid
);

  import l1d_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_MISS_REQ,
    ST_FILL,
    ST_EVICT,
    ST_REPLAY,
    ST_RESP
  } state_t;

  state_t      state_q;
  state_t      next_state;
  logic        replay_q;
  lsu_req_t    req_q;
  lc_fill_t    fill_q;
  lsu_resp_t   resp_q;
  lc_req_t     lc_req_q;
  block_addr_t req_block;

  // stores echo their own value, loads return the word from the line
  function automatic lsu_resp_t make_resp(input lsu_req_t r,
                                          input logic [`L1D_WORD_BITS-1:0] rd);
    lsu_resp_t resp;
    resp.addr  = r.addr.raw;
    resp.write = r.we;
    resp.value = r.we ? r.value : rd;
    resp.tag   = r.tag;
    return resp;
  endfunction

  assign req_block = req_q.addr.raw[`L1D_PADDR_BITS-1:`L1D_OFFSET_BITS];

  // a waiting fill holds off new LSU requests
  assign lsu_req_ready  = (state_q == ST_IDLE) && !lc_fill_valid && any_free && !any_full;
  assign lc_fill_ready  = (state_q == ST_IDLE) && lc_fill_valid;
  assign lsu_resp_valid = (state_q == ST_RESP);
  assign lsu_resp       = resp_q;
  assign lc_req_valid   = (state_q == ST_MISS_REQ) || (state_q == ST_EVICT);
  assign lc_req         = lc_req_q;

  // during replay the line store serves the head of the filled block's queue
  assign lookup_addr  = (state_q == ST_REPLAY) ? head.addr : req_q.addr;
  assign word_value   = (state_q == ST_REPLAY) ? head.value : req_q.value;
  assign fill         = fill_q;
  assign lookup_block = (state_q == ST_LOOKUP) ? req_block : fill_q.block;
  assign req          = req_q;
  assign deq_id       = match_id;

  always_comb begin
    next_state = state_q;
    word_we    = 1'b0;
    fill_en    = 1'b0;
    alloc_en   = 1'b0;
    enq_en     = 1'b0;
    deq_en     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (lc_fill_valid) begin
          next_state = ST_FILL;
        end else if (lsu_req_valid && lsu_req_ready) begin
          next_state = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          word_we    = req_q.we;
          next_state = ST_RESP;
        end else if (match) begin
          // secondary miss, the line request is already out
          enq_en     = 1'b1;
          next_state = ST_IDLE;
        end else begin
          alloc_en   = 1'b1;
          next_state = ST_MISS_REQ;
        end
      end
      ST_MISS_REQ: begin
        if (lc_req_ready) begin
          next_state = ST_IDLE;
        end
      end
      ST_FILL: begin
        if (victim_dirty) begin
          next_state = ST_EVICT;
        end else begin
          fill_en    = 1'b1;
          next_state = ST_REPLAY;
        end
      end
      ST_EVICT: begin
        // the victim copy is already in lc_req_q, so the line can be replaced now
        if (lc_req_ready) begin
          fill_en    = 1'b1;
          next_state = ST_REPLAY;
        end
      end
      ST_REPLAY: begin
        if (head_valid) begin
          deq_en     = 1'b1;
          word_we    = head.we;
          next_state = ST_RESP;
        end else begin
          next_state = ST_IDLE;
        end
      end
      ST_RESP: begin
        if (lsu_resp_ready) begin
          next_state = replay_q ? ST_REPLAY : ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q  <= ST_IDLE;
      replay_q <= 1'b0;
    end else begin
      state_q <= next_state;
      if (state_q == ST_REPLAY) begin
        replay_q <= 1'b1;
      end else if (state_q == ST_LOOKUP) begin
        replay_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (lc_fill_ready) begin
      fill_q <= lc_fill;
    end
    if (lsu_req_valid && lsu_req_ready) begin
      req_q <= lsu_req;
    end
    if (alloc_en) begin
      lc_req_q <= '{block: req_block, we: 1'b0, line: '0};
    end else if ((state_q == ST_FILL) && victim_dirty) begin
      lc_req_q <= victim;
    end
    if ((state_q == ST_LOOKUP) && hit) begin
      resp_q <= make_resp(req_q, read_word);
    end else if (deq_en) begin
      resp_q <= make_resp(head, read_word);
    end
  end

  // the lower cache may stall, and the request must not change under it
  lc_req_held: assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
      lc_req_valid && !lc_req_ready |=> lc_req_valid && $stable(lc_req)
  ) else $error("lc_req changed while waiting for lc_req_ready");

endmodule

`default_nettype wire

// File: verilog/l1d_defines.svh
// L1 data cache parameters

`ifndef L1D_DEFINES_SVH
`define L1D_DEFINES_SVH

// physical address and data word widths
`define L1D_PADDR_BITS 22
`define L1D_WORD_BITS 64

// line geometry, with the offset split into word select and byte within word
`define L1D_LINE_BYTES 64
`define L1D_OFFSET_BITS $clog2(`L1D_LINE_BYTES)
`define L1D_WORD_SEL_BITS 3
`define L1D_LINE_BITS (8 * `L1D_LINE_BYTES)

// direct mapped, so one line per index
`define L1D_LINE_COUNT 16
`define L1D_INDEX_BITS $clog2(`L1D_LINE_COUNT)
`define L1D_TAG_BITS (`L1D_PADDR_BITS - `L1D_INDEX_BITS - `L1D_OFFSET_BITS)

// tag the LSU attaches to each request and expects back in the response
`define L1D_REQ_TAG_BITS 10

// miss handling resources
`define L1D_MSHR_COUNT 4
`define L1D_MSHR_DEPTH 4

`endif

// File: verilog/l1d_line_store.sv
// Direct-mapped line store

`include "l1d_defines.svh"

`default_nettype none

module l1d_line_store (
  input  logic                       clk_in,
  input  logic                       rst_N_in,
  input  l1d_pkg::paddr_u            lookup_addr,
  input  logic                       word_we,
  input  logic [`L1D_WORD_BITS-1:0]  word_value,
  input  logic                       fill_en,
  input  l1d_pkg::lc_fill_t          fill,
  output logic                       hit,
  output logic [`L1D_WORD_BITS-1:0]  read_word,
  output logic                       victim_dirty,
  output l1d_pkg::lc_req_t           victim
);

  logic [`L1D_LINE_COUNT-1:0]    valid_q;
  logic [`L1D_LINE_COUNT-1:0]    dirty_q;
  logic [`L1D_TAG_BITS-1:0]      tag_q [`L1D_LINE_COUNT];
  logic [`L1D_LINE_BITS-1:0]     data_q [`L1D_LINE_COUNT];

  logic [`L1D_INDEX_BITS-1:0]    idx;
  logic [`L1D_WORD_SEL_BITS-1:0] word_sel;
  logic [`L1D_INDEX_BITS-1:0]    fill_idx;
  logic [`L1D_TAG_BITS-1:0]      fill_tag;

  assign idx      = lookup_addr.f.index;
  assign word_sel = lookup_addr.f.offset[`L1D_OFFSET_BITS-1 -: `L1D_WORD_SEL_BITS];

  // the fill block address is tag over index
  assign fill_idx = fill.block[`L1D_INDEX_BITS-1:0];
  assign fill_tag = fill.block[`L1D_INDEX_BITS +: `L1D_TAG_BITS];

  assign hit       = valid_q[idx] && (tag_q[idx] == lookup_addr.f.tag);
  assign read_word = data_q[idx][word_sel*`L1D_WORD_BITS +: `L1D_WORD_BITS];

  // whatever sits at the fill index is what the fill would displace
  assign victim_dirty = valid_q[fill_idx] && dirty_q[fill_idx];
  assign victim       = '{block: {tag_q[fill_idx], fill_idx},
                          we:    1'b1,
                          line:  data_q[fill_idx]};

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_idx] <= 1'b1;
      dirty_q[fill_idx] <= 1'b0;
    end else if (word_we) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill_en) begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= fill.line;
    end else if (word_we) begin
      data_q[idx][word_sel*`L1D_WORD_BITS +: `L1D_WORD_BITS] <= word_value;
    end
  end

  // the controller installs and stores in separate states
  no_store_during_fill: assert property (
    @(posedge clk_in) disable iff (!rst_N_in) !(word_we && fill_en)
  ) else $error("line store got a word write and a fill together");

endmodule

`default_nettype wire

// File: verilog/l1d_mshr_file.sv
// MSHR file with per-entry request queues

`include "l1d_defines.svh"

`default_nettype none

module l1d_mshr_file (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  l1d_pkg::block_addr_t lookup_block,
  input  logic                 alloc_en,
  input  logic                 enq_en,
  input  l1d_pkg::lsu_req_t    req,
  input  logic                 deq_en,
  input  l1d_pkg::mshr_id_t    deq_id,
  output logic                 match,
  output l1d_pkg::mshr_id_t    match_id,
  output logic                 any_free,
  output logic                 any_full,
  output l1d_pkg::lsu_req_t    head,
  output logic                 head_valid
);

  import l1d_pkg::*;

  localparam int PTR_BITS = $clog2(`L1D_MSHR_DEPTH);
  localparam int CNT_BITS = $clog2(`L1D_MSHR_DEPTH + 1);

  logic [`L1D_MSHR_COUNT-1:0] valid_q;
  block_addr_t                block_q [`L1D_MSHR_COUNT];
  lsu_req_t                   queue_q [`L1D_MSHR_COUNT][`L1D_MSHR_DEPTH];
  logic [PTR_BITS-1:0]        rd_ptr_q [`L1D_MSHR_COUNT];
  logic [PTR_BITS-1:0]        wr_ptr_q [`L1D_MSHR_COUNT];
  logic [CNT_BITS-1:0]        count_q [`L1D_MSHR_COUNT];

  logic [`L1D_MSHR_COUNT-1:0] full_vec;
  mshr_id_t                   free_id;
  logic                       dup_block;

  // scanning downward leaves the lowest matching and lowest free entry
  always_comb begin
    match    = 1'b0;
    match_id = '0;
    any_free = 1'b0;
    free_id  = '0;
    for (int i = `L1D_MSHR_COUNT - 1; i >= 0; i--) begin
      full_vec[i] = valid_q[i] && (count_q[i] == CNT_BITS'(`L1D_MSHR_DEPTH));
      if (valid_q[i] && (block_q[i] == lookup_block)) begin
        match    = 1'b1;
        match_id = mshr_id_t'(i);
      end
      if (!valid_q[i]) begin
        any_free = 1'b1;
        free_id  = mshr_id_t'(i);
      end
    end
  end

  assign any_full   = |full_vec;
  assign head       = queue_q[match_id][rd_ptr_q[match_id]];
  assign head_valid = match && (count_q[match_id] != '0);

  // an entry lives from its primary miss until its last queued request drains
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < `L1D_MSHR_COUNT; i++) begin
        rd_ptr_q[i] <= '0;
        wr_ptr_q[i] <= '0;
        count_q[i]  <= '0;
      end
    end else begin
      if (alloc_en) begin
        valid_q[free_id]  <= 1'b1;
        rd_ptr_q[free_id] <= '0;
        wr_ptr_q[free_id] <= PTR_BITS'(1);
        count_q[free_id]  <= CNT_BITS'(1);
      end
      if (enq_en) begin
        wr_ptr_q[match_id] <= wr_ptr_q[match_id] + 1'b1;
        count_q[match_id]  <= count_q[match_id] + 1'b1;
      end
      if (deq_en) begin
        rd_ptr_q[deq_id] <= rd_ptr_q[deq_id] + 1'b1;
        count_q[deq_id]  <= count_q[deq_id] - 1'b1;
        if (count_q[deq_id] == CNT_BITS'(1)) begin
          valid_q[deq_id] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_en) begin
      block_q[free_id]    <= lookup_block;
      queue_q[free_id][0] <= req;
    end else if (enq_en) begin
      queue_q[match_id][wr_ptr_q[match_id]] <= req;
    end
  end

  always_comb begin
    dup_block = 1'b0;
    for (int i = 0; i < `L1D_MSHR_COUNT; i++) begin
      for (int j = i + 1; j < `L1D_MSHR_COUNT; j++) begin
        if (valid_q[i] && valid_q[j] && (block_q[i] == block_q[j])) begin
          dup_block = 1'b1;
        end
      end
    end
  end

  // the controller stops taking requests while any queue is full
  no_enqueue_when_full: assert property (
    @(posedge clk_in) disable iff (!rst_N_in) enq_en |-> match && !full_vec[match_id]
  ) else $error("enqueue into a full or missing MSHR queue");

  // a secondary miss must merge, never allocate a second entry
  unique_blocks: assert property (
    @(posedge clk_in) disable iff (!rst_N_in) !dup_block
  ) else $error("two MSHR entries track the same block");

endmodule

`default_nettype wire

// File: verilog/l1d_pkg.sv
// L1 data cache types

`include "l1d_defines.svh"

`default_nettype none

package l1d_pkg;

  typedef struct packed {
    logic [`L1D_TAG_BITS-1:0]    tag;
    logic [`L1D_INDEX_BITS-1:0]  index;
    logic [`L1D_OFFSET_BITS-1:0] offset;
  } paddr_fields_t;

  // the same physical address word, seen whole or split for the arrays
  typedef union packed {
    logic [`L1D_PADDR_BITS-1:0] raw;
    paddr_fields_t              f;
  } paddr_u;

  typedef logic [`L1D_PADDR_BITS-`L1D_OFFSET_BITS-1:0] block_addr_t;

  typedef struct packed {
    paddr_u                       addr;
    logic                         we;
    logic [`L1D_WORD_BITS-1:0]    value;
    logic [`L1D_REQ_TAG_BITS-1:0] tag;
  } lsu_req_t;

  typedef struct packed {
    logic [`L1D_PADDR_BITS-1:0]   addr;
    logic                         write;
    logic [`L1D_WORD_BITS-1:0]    value;
    logic [`L1D_REQ_TAG_BITS-1:0] tag;
  } lsu_resp_t;

  // line reads carry we low and ignore the line, evictions carry we high
  typedef struct packed {
    block_addr_t               block;
    logic                      we;
    logic [`L1D_LINE_BITS-1:0] line;
  } lc_req_t;

  typedef struct packed {
    block_addr_t               block;
    logic [`L1D_LINE_BITS-1:0] line;
  } lc_fill_t;

  typedef logic [$clog2(`L1D_MSHR_COUNT)-1:0] mshr_id_t;

endpackage

`default_nettype wire
